// ==== filelist.f ====
design/uop_pkg.sv
design/ibuffer_fifo.sv
design/uop_counter.sv
design/uop_expander.sv
design/uop_sequencer.sv
design/issue_slice.sv
testbench/issue_slice_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compiles the issue slice testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module issue_slice_tb -f filelist.f -o issue_slice_sim; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/issue_slice_sim)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** PASSED ***' <<< "$output"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== testbench/issue_slice_tb.sv ====
// ##########################################################
// random stimulus, queue reference model, output checks and
// cycle timeout for the issue slice
// ##########################################################

module issue_slice_tb;

    localparam int FIFO_DEPTH  = 4;
    localparam int NUM_UOPS    = 4;
    localparam int NUM_ENTRIES = 300;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * (NUM_UOPS + 2) * 4;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    logic                 in_ready;
    uop_pkg::ibuf_entry_t in_entry;
    logic                 out_valid;
    logic                 out_ready;
    uop_pkg::ibuf_entry_t out_entry;

    // expected outputs in order and a flag for the step that frees a FIFO slot
    uop_pkg::ibuf_entry_t exp_q[$];
    bit                   pop_q[$];

    integer seed;
    int     cycle_count;
    int     occupancy;
    int     issued;
    int     accepted;
    int     stall_left;
    bit     saw_full;
    bit     finished;

    issue_slice #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .NUM_UOPS   (NUM_UOPS)
    ) issue_slice_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_entry  (in_entry),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_entry (out_entry)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            stop_on_error($sformatf("Mismatch at time %0t: %s expected 0x%0h, actual 0x%0h",
                                    $time, name, expected, actual));
        end
    endtask

    task automatic compare_entry(input uop_pkg::ibuf_entry_t expected,
                                 input uop_pkg::ibuf_entry_t actual);
        check_value("out_entry.uuid", 64'(expected.uuid), 64'(actual.uuid));
        check_value("out_entry.pc", 64'(expected.pc), 64'(actual.pc));
        check_value("out_entry.ex_type", 64'(expected.ex_type), 64'(actual.ex_type));
        check_value("out_entry.op", 64'(expected.op), 64'(actual.op));
        check_value("out_entry.rd", 64'(expected.rd), 64'(actual.rd));
        check_value("out_entry.rs1", 64'(expected.rs1), 64'(actual.rs1));
        check_value("out_entry.rs2", 64'(expected.rs2), 64'(actual.rs2));
        check_value("out_entry.rs3", 64'(expected.rs3), 64'(actual.rs3));
        check_value("out_entry.uop_idx", 64'(expected.uop_idx), 64'(actual.uop_idx));
    endtask

    // roughly one macro in four plus some MMA loads that must not expand
    task automatic make_entry(output uop_pkg::ibuf_entry_t e);
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $random(seed);
        r2 = $random(seed);
        e.uuid    = r1[7:0];
        e.pc      = r1[23:8];
        e.rd      = r2[4:0];
        e.rs1     = r2[9:5];
        e.rs2     = r2[14:10];
        e.rs3     = r2[19:15];
        e.uop_idx = r2[22:20];
        if (r1[25:24] == 2'd0) begin
            e.ex_type = uop_pkg::EX_MMA;
            e.op      = uop_pkg::OP_WMMA;
        end else if (r1[27:26] == 2'd0) begin
            e.ex_type = uop_pkg::EX_MMA;
            e.op      = uop_pkg::OP_MMA_LOAD;
        end else begin
            e.ex_type = uop_pkg::ex_type_e'(r2[24:23]);
            e.op      = uop_pkg::op_e'(3'(r2[31:25] % 7));
            if (e.ex_type == uop_pkg::EX_MMA && e.op == uop_pkg::OP_WMMA) begin
                e.op = uop_pkg::OP_FMA;
            end
        end
    endtask

    // expands an accepted entry into its expected outputs with register sums wrapping at 32
    task automatic push_expected(input uop_pkg::ibuf_entry_t e);
        uop_pkg::ibuf_entry_t u;
        int k;
        if (e.ex_type == uop_pkg::EX_MMA && e.op == uop_pkg::OP_WMMA) begin
            for (k = 0; k < NUM_UOPS; k++) begin
                u         = e;
                u.rd      = 5'((int'(e.rd) + k) % 32);
                u.rs1     = 5'((int'(e.rs1) + k / 2) % 32);
                u.rs2     = 5'((int'(e.rs2) + k % 2) % 32);
                u.rs3     = u.rd;
                u.uop_idx = 3'(k);
                exp_q.push_back(u);
                pop_q.push_back(k == NUM_UOPS - 1);
            end
        end else begin
            u         = e;
            u.uop_idx = '0;
            exp_q.push_back(u);
            pop_q.push_back(1'b1);
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        assert (cycle_count < CYCLE_LIMIT) else begin
            stop_on_error("timeout, the expected outputs did not all arrive in time");
        end
    end

    initial begin
        logic [31:0]          r;
        logic                 in_fire;
        logic                 out_fire;
        logic                 prev_valid;
        logic                 prev_ready;
        uop_pkg::ibuf_entry_t prev_entry;
        uop_pkg::ibuf_entry_t next_entry;

        seed        = 32'hf4ca_8994;
        cycle_count = 0;
        occupancy   = 0;
        issued      = 0;
        accepted    = 0;
        stall_left  = 0;
        saw_full    = 1'b0;
        finished    = 1'b0;
        prev_valid  = 1'b0;
        prev_ready  = 1'b0;
        prev_entry  = '0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_entry    = '0;
        out_ready   = 1'b0;

        repeat (10) @(posedge clk);
        check_value("out_valid", 64'(1'b0), 64'(out_valid));
        check_value("in_ready", 64'(1'b1), 64'(in_ready));
        reset <= 1'b0;

        while (!finished) begin
            @(posedge clk);
            in_fire  = in_valid && in_ready;
            out_fire = out_valid && out_ready;

            check_value("in_ready", 64'(occupancy != FIFO_DEPTH), 64'(in_ready));
            if (!in_ready) begin
                saw_full = 1'b1;
            end

            // an offered but unaccepted output must be held unchanged
            if (prev_valid && !prev_ready) begin
                check_value("out_valid", 64'(1'b1), 64'(out_valid));
                check_value("out_entry", 64'(prev_entry), 64'(out_entry));
            end

            if (out_fire) begin
                assert (exp_q.size() > 0) else begin
                    stop_on_error("an output was accepted while no output was expected");
                end
                compare_entry(exp_q[0], out_entry);
                if (pop_q[0]) begin
                    occupancy--;
                end
                void'(exp_q.pop_front());
                void'(pop_q.pop_front());
            end

            if (in_fire) begin
                occupancy++;
                accepted++;
                push_expected(in_entry);
            end

            prev_valid = out_valid;
            prev_ready = out_ready;
            prev_entry = out_entry;

            if (accepted == NUM_ENTRIES && exp_q.size() == 0) begin
                finished = 1'b1;
            end else begin
                r = $random(seed);
                // a pending input keeps its entry until it is taken
                if (!in_valid || in_fire) begin
                    if (issued < NUM_ENTRIES && r[1:0] != 2'd0) begin
                        make_entry(next_entry);
                        in_entry <= next_entry;
                        in_valid <= 1'b1;
                        issued++;
                    end else begin
                        in_valid <= 1'b0;
                    end
                end
                // long stalls fill the FIFO, otherwise out_ready is mostly high
                if (stall_left > 0) begin
                    out_ready <= 1'b0;
                    stall_left--;
                end else if (r[9:4] == 6'd0) begin
                    stall_left = 10 + int'(r[14:10]);
                    out_ready <= 1'b0;
                end else begin
                    out_ready <= (r[17:16] != 2'd0);
                end
            end
        end

        if (saw_full) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_on_error("the FIFO never filled up, so back-pressure was not exercised");
        end
    end

endmodule

// ==== design/issue_slice.sv ====
// ##########################################################
// top level with the instruction buffer followed by the
// micro-op sequencer and its step counter and expander
// ##########################################################

module issue_slice #(
    parameter int FIFO_DEPTH = 4,
    parameter int NUM_UOPS   = 4
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 in_valid,
    output logic                 in_ready,
    input  uop_pkg::ibuf_entry_t in_entry,

    output logic                 out_valid,
    input  logic                 out_ready,
    output uop_pkg::ibuf_entry_t out_entry
);

    logic                          fifo_valid;
    logic                          fifo_ready;
    uop_pkg::ibuf_entry_t          fifo_entry;
    uop_pkg::ibuf_entry_t          uop_entry;
    logic                          cnt_start;
    logic                          cnt_advance;
    logic [uop_pkg::UOP_IDX_W-1:0] cnt_idx;
    logic                          cnt_last;

    ibuffer_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) ibuffer_fifo_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_entry  (in_entry),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready),
        .out_entry (fifo_entry)
    );

    uop_sequencer uop_sequencer_inst (
        .clk         (clk),
        .reset       (reset),
        .fifo_valid  (fifo_valid),
        .fifo_ready  (fifo_ready),
        .fifo_entry  (fifo_entry),
        .uop_entry   (uop_entry),
        .cnt_last    (cnt_last),
        .cnt_start   (cnt_start),
        .cnt_advance (cnt_advance),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_entry   (out_entry)
    );

    uop_counter #(
        .NUM_UOPS (NUM_UOPS)
    ) uop_counter_inst (
        .clk     (clk),
        .reset   (reset),
        .start   (cnt_start),
        .advance (cnt_advance),
        .idx     (cnt_idx),
        .last    (cnt_last)
    );

    // the expander always works on the entry at the FIFO head
    uop_expander uop_expander_inst (
        .macro_entry (fifo_entry),
        .idx         (cnt_idx),
        .uop_entry   (uop_entry)
    );

endmodule

// ==== design/uop_sequencer.sv ====
// ##########################################################
// passes plain entries through and issues the micro-ops
// of a matrix macro one per transfer
// ##########################################################

module uop_sequencer (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 fifo_valid,
    output logic                 fifo_ready,
    input  uop_pkg::ibuf_entry_t fifo_entry,

    input  uop_pkg::ibuf_entry_t uop_entry,
    input  logic                 cnt_last,
    output logic                 cnt_start,
    output logic                 cnt_advance,

    output logic                 out_valid,
    input  logic                 out_ready,
    output uop_pkg::ibuf_entry_t out_entry
);

    typedef enum logic {
        IDLE,
        EXPAND
    } state_e;

    state_e state;
    state_e state_next;

    logic is_macro;
    logic hold;

    uop_pkg::ibuf_entry_t pass_entry;

    assign is_macro = (fifo_entry.ex_type == uop_pkg::EX_MMA)
                   && (fifo_entry.op == uop_pkg::OP_WMMA);

    // first cycle a macro shows up is spent loading the counter
    assign hold = (state == IDLE) && fifo_valid && is_macro;

    always_comb begin
        pass_entry         = fifo_entry;
        pass_entry.uop_idx = '0;
    end

    always_comb begin
        state_next  = state;
        cnt_start   = 1'b0;
        cnt_advance = 1'b0;
        out_valid   = 1'b0;
        fifo_ready  = 1'b0;
        out_entry   = pass_entry;
        case (state)
            IDLE: begin
                if (hold) begin
                    cnt_start  = 1'b1;
                    state_next = EXPAND;
                end else begin
                    // plain entries cost no cycle in the sequencer
                    out_valid  = fifo_valid;
                    fifo_ready = out_ready;
                end
            end
            EXPAND: begin
                // the macro stays at the FIFO head until its last step is taken
                out_valid   = 1'b1;
                out_entry   = uop_entry;
                cnt_advance = out_ready;
                fifo_ready  = out_ready && cnt_last;
                if (out_ready && cnt_last) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== design/uop_expander.sv ====
// ##########################################################
// builds one micro-op of a matrix macro from the macro
// entry and the current step index
// ##########################################################

module uop_expander (
    input  uop_pkg::ibuf_entry_t          macro_entry,
    input  logic [uop_pkg::UOP_IDX_W-1:0] idx,
    output uop_pkg::ibuf_entry_t          uop_entry
);

    // register offsets derived from the step index
    logic [uop_pkg::REG_W-1:0] rd_off;
    logic [uop_pkg::REG_W-1:0] rs1_off;
    logic [uop_pkg::REG_W-1:0] rs2_off;

    logic [uop_pkg::REG_W-1:0] new_rd;

    // destination walks one register per step
    assign rd_off = uop_pkg::REG_W'(idx);

    // source A advances every second step
    assign rs1_off = uop_pkg::REG_W'(idx >> 1);

    // source B alternates between the base register and the next one
    assign rs2_off = uop_pkg::REG_W'(idx[0]);

    // sums are REG_W wide, so high indices wrap around to r0
    assign new_rd = macro_entry.rd + rd_off;

    always_comb begin
        // tag, pc, unit and opcode are carried over from the macro
        uop_entry = macro_entry;

        uop_entry.rd  = new_rd;
        uop_entry.rs1 = macro_entry.rs1 + rs1_off;
        uop_entry.rs2 = macro_entry.rs2 + rs2_off;

        // each step accumulates into its own destination
        uop_entry.rs3 = new_rd;

        uop_entry.uop_idx = idx;
    end

endmodule

// ==== design/uop_counter.sv ====
// ##########################################################
// step index of the micro-op being issued
// ##########################################################

module uop_counter #(
    parameter int NUM_UOPS = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          advance,
    output logic [uop_pkg::UOP_IDX_W-1:0] idx,
    output logic                          last
);

    localparam logic [uop_pkg::UOP_IDX_W-1:0] LAST_IDX =
        uop_pkg::UOP_IDX_W'(NUM_UOPS - 1);

    // start wins over advance so a new macro always begins at step zero
    always_ff @(posedge clk) begin
        if (reset) begin
            idx <= '0;
        end else if (start) begin
            idx <= '0;
        end else if (advance) begin
            idx <= idx + 1'b1;
        end
    end

    // tells the sequencer that the current micro-op closes the macro
    assign last = (idx == LAST_IDX);

endmodule

// ==== design/ibuffer_fifo.sv ====
// ##########################################################
// registered circular buffer of decoded instruction entries
// with valid/ready on both sides
// ##########################################################

module ibuffer_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 in_valid,
    output logic                 in_ready,
    input  uop_pkg::ibuf_entry_t in_entry,

    output logic                 out_valid,
    input  logic                 out_ready,
    output uop_pkg::ibuf_entry_t out_entry
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    uop_pkg::ibuf_entry_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_entry = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // entry storage is written only when a push is accepted
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_entry;
        end
    end

    // pointers wrap explicitly so DEPTH need not be a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // a simultaneous push and pop leaves the occupancy unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== design/uop_pkg.sv ====
// ##########################################################
// shared field widths, execution type and opcode enums, and
// the instruction buffer entry struct
// ##########################################################

package uop_pkg;

    // register index width, enough for 32 architectural registers
    localparam int REG_W = 5;

    // instruction tag width
    localparam int UUID_W = 8;

    // program counter width
    localparam int PC_W = 16;

    // micro-op index width, allows up to 8 micro-ops per macro
    localparam int UOP_IDX_W = 3;

    // execution unit that will consume the instruction
    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_FPU = 2'd2,
        EX_MMA = 2'd3
    } ex_type_e;

    // opcodes, only the pair EX_MMA with OP_WMMA is a macro
    typedef enum logic [2:0] {
        OP_ADD      = 3'd0,
        OP_SUB      = 3'd1,
        OP_LOAD     = 3'd2,
        OP_STORE    = 3'd3,
        OP_FMA      = 3'd4,
        OP_WMMA     = 3'd5,
        OP_MMA_LOAD = 3'd6
    } op_e;

    // one decoded instruction as held in the instruction buffer
    typedef struct packed {
        logic [UUID_W-1:0]    uuid;
        logic [PC_W-1:0]      pc;
        ex_type_e             ex_type;
        op_e                  op;
        logic [REG_W-1:0]     rd;
        logic [REG_W-1:0]     rs1;
        logic [REG_W-1:0]     rs2;
        logic [REG_W-1:0]     rs3;
        logic [UOP_IDX_W-1:0] uop_idx;
    } ibuf_entry_t;

endpackage
